// File: src/ipod_pkg.sv
package ipod_pkg;

  // ==========================================================================
  // Flash and sample geometry
  // ==========================================================================
  localparam int addr_w = 23;
  localparam logic [addr_w-1:0] last_addr = 23'h7FFFF;
  localparam int sample_w = 16;

  // ==========================================================================
  // Sample-rate divider, scaled down for simulation
  // ==========================================================================
  localparam int div_w = 24;
  localparam logic [div_w-1:0] default_div = 24'd50;
  localparam logic [div_w-1:0] min_div = 24'd8;
  localparam logic [div_w-1:0] max_div = 24'd200;
  localparam logic [div_w-1:0] speed_step = 24'd4;
  // Button repeat period in clock cycles
  localparam int repeat_cycles = 16;

  // PS/2 set-2 make codes of the player keys
  localparam logic [7:0] scan_play = 8'h24;
  localparam logic [7:0] scan_pause = 8'h23;
  localparam logic [7:0] scan_forward = 8'h2B;
  localparam logic [7:0] scan_backward = 8'h32;
  localparam logic [7:0] scan_restart = 8'h2D;

  typedef enum logic [2:0] {
    cmd_none,
    cmd_play,
    cmd_pause,
    cmd_forward,
    cmd_backward,
    cmd_restart
  } player_cmd_e;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data,
    st_second_half
  } reader_state_e;

  // One-cycle speed requests
  typedef struct packed {
    logic up;
    logic down;
    logic restore;
  } speed_req_t;

  typedef struct packed {
    logic              read;
    logic [addr_w-1:0] address;
  } flash_req_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    logic [31:0] readdata;
  } flash_rsp_t;

  // Active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

endpackage

// File: src/player_input.sv
`timescale 1ns/1ps

module player_input (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  logic [2:0]             key,
  input  logic [7:0]             kbd_scan_code,
  input  logic                   kbd_ready,
  output ipod_pkg::speed_req_t   speed_req,
  output ipod_pkg::player_cmd_e  cmd
);

  logic [2:0] key_meta;
  logic [2:0] key_sync;
  logic       restore_prev;
  logic [$clog2(ipod_pkg::repeat_cycles)-1:0] rep_cnt;
  logic       rep_wrap;
  logic [2:0] pressed;

  // ==========================================================================
  // Button synchronizer and repeat timer
  // ==========================================================================
  // Buttons idle high, so reset to released
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta     <= 3'b111;
      key_sync     <= 3'b111;
      restore_prev <= 1'b0;
    end
    else
    begin
      key_meta     <= key;
      key_sync     <= key_meta;
      restore_prev <= pressed[2];
    end
  end

  assign pressed = ~key_sync;

  // Free-running, one step window per period
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rep_cnt <= '0;
    else if (rep_wrap)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 1'b1;
  end

  assign rep_wrap = (rep_cnt == ipod_pkg::repeat_cycles - 1);

  assign speed_req.up      = pressed[0] & rep_wrap;
  assign speed_req.down    = pressed[1] & rep_wrap;
  assign speed_req.restore = pressed[2] & ~restore_prev;

  // ==========================================================================
  // Keyboard command decode
  // ==========================================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      cmd <= ipod_pkg::cmd_none;
    else if (kbd_ready)
    begin
      case (kbd_scan_code)
        ipod_pkg::scan_play:     cmd <= ipod_pkg::cmd_play;
        ipod_pkg::scan_pause:    cmd <= ipod_pkg::cmd_pause;
        ipod_pkg::scan_forward:  cmd <= ipod_pkg::cmd_forward;
        ipod_pkg::scan_backward: cmd <= ipod_pkg::cmd_backward;
        ipod_pkg::scan_restart:  cmd <= ipod_pkg::cmd_restart;
        default:                 cmd <= ipod_pkg::cmd_none;
      endcase
    end
    else
      cmd <= ipod_pkg::cmd_none;
  end

endmodule

// File: src/sample_clock.sv
`timescale 1ns/1ps

module sample_clock (
  input  logic                       CLK_50M,
  input  logic                       arst_n,
  input  ipod_pkg::speed_req_t       speed_req,
  output logic [ipod_pkg::div_w-1:0] div_count,
  output logic                       sample_tick
);

  logic [ipod_pkg::div_w-1:0] tick_cnt;

  // Speed register, restore has priority, up wins over down
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      div_count <= ipod_pkg::default_div;
    else if (speed_req.restore)
      div_count <= ipod_pkg::default_div;
    else if (speed_req.up)
    begin
      // Faster playback means a shorter period
      if (div_count < ipod_pkg::min_div + ipod_pkg::speed_step)
        div_count <= ipod_pkg::min_div;
      else
        div_count <= div_count - ipod_pkg::speed_step;
    end
    else if (speed_req.down)
    begin
      if (div_count > ipod_pkg::max_div - ipod_pkg::speed_step)
        div_count <= ipod_pkg::max_div;
      else
        div_count <= div_count + ipod_pkg::speed_step;
    end
  end

  // Period of exactly div_count cycles; a shrinking count restarts at once
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt >= div_count - 1'b1)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

// File: src/flash_reader.sv
`timescale 1ns/1ps

module flash_reader (
  input  logic                          CLK_50M,
  input  logic                          arst_n,
  input  ipod_pkg::player_cmd_e         cmd,
  input  logic                          sample_tick,
  output ipod_pkg::flash_req_t          flash_req,
  input  ipod_pkg::flash_rsp_t          flash_rsp,
  output logic [ipod_pkg::sample_w-1:0] audio_data,
  output logic                          sample_valid
);

  ipod_pkg::reader_state_e       state;
  ipod_pkg::flash_req_t          req_q;
  logic [ipod_pkg::addr_w-1:0]   addr;
  logic [ipod_pkg::addr_w-1:0]   next_addr;
  logic [ipod_pkg::sample_w-1:0] held_half;
  logic                          playing;
  logic                          dir_fwd;
  logic                          drop_word;
  logic                          word_in;

  assign flash_req = req_q;
  assign word_in   = (state == ipod_pkg::st_wait_data) && flash_rsp.readdatavalid;

  // Word address stepping with wrap at both ends
  always_comb
  begin
    if (dir_fwd)
      next_addr = (addr == ipod_pkg::last_addr) ? '0 : addr + 1'b1;
    else
      next_addr = (addr == '0) ? ipod_pkg::last_addr : addr - 1'b1;
  end

  // ==========================================================================
  // Read FSM and command handling
  // ==========================================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= ipod_pkg::st_idle;
      req_q        <= '0;
      addr         <= '0;
      playing      <= 1'b0;
      dir_fwd      <= 1'b1;
      drop_word    <= 1'b0;
      audio_data   <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      case (state)
        ipod_pkg::st_idle:
          if (playing && sample_tick)
          begin
            req_q.read    <= 1'b1;
            req_q.address <= addr;
            state         <= ipod_pkg::st_request;
          end
        ipod_pkg::st_request:
          if (!flash_rsp.waitrequest)
          begin
            req_q.read <= 1'b0;
            state      <= ipod_pkg::st_wait_data;
          end
        ipod_pkg::st_wait_data:
          if (flash_rsp.readdatavalid)
          begin
            drop_word <= 1'b0;
            // A word that lands while paused is fetched again after play
            if (playing && !drop_word)
            begin
              audio_data   <= dir_fwd ? flash_rsp.readdata[15:0]
                                      : flash_rsp.readdata[31:16];
              sample_valid <= 1'b1;
              state        <= ipod_pkg::st_second_half;
            end
            else
              state <= ipod_pkg::st_idle;
          end
        ipod_pkg::st_second_half:
          if (playing && sample_tick)
          begin
            audio_data   <= held_half;
            sample_valid <= 1'b1;
            addr         <= next_addr;
            state        <= ipod_pkg::st_idle;
          end
        default:
          state <= ipod_pkg::st_idle;
      endcase

      case (cmd)
        ipod_pkg::cmd_play:     playing <= 1'b1;
        ipod_pkg::cmd_pause:    playing <= 1'b0;
        ipod_pkg::cmd_forward:  dir_fwd <= 1'b1;
        ipod_pkg::cmd_backward: dir_fwd <= 1'b0;
        ipod_pkg::cmd_restart:
        begin
          addr <= '0;
          // Any half in hand belongs to the old position
          if (state == ipod_pkg::st_second_half || word_in)
            state <= ipod_pkg::st_idle;
          // A read leaving in this cycle still carries the old address
          else if (state != ipod_pkg::st_idle || (playing && sample_tick))
            drop_word <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Other half of the word waits here for the next tick
  always_ff @(posedge CLK_50M)
  begin
    if (word_in)
      held_half <= dir_fwd ? flash_rsp.readdata[31:16] : flash_rsp.readdata[15:0];
  end

endmodule

// File: src/display_out.sv
`timescale 1ns/1ps

module display_out (
  input  logic                       CLK_50M,
  input  logic                       arst_n,
  input  logic [ipod_pkg::div_w-1:0] div_count,
  output ipod_pkg::seg_t [5:0]       hex
);

  // Hex digit to active-low segments, gfedcba
  function automatic ipod_pkg::seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // Digit 0 shows the lowest nibble; blank during reset
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      hex <= {6{7'h7F}};
    else
    begin
      for (int i = 0; i < 6; i++)
        hex[i] <= seg_decode(div_count[4*i +: 4]);
    end
  end

endmodule

// File: src/simple_ipod_top.sv
`timescale 1ns/1ps

module simple_ipod_top (
  input  logic                          CLK_50M,
  input  logic                          arst_n,
  input  logic [2:0]                    key,
  input  logic [7:0]                    kbd_scan_code,
  input  logic                          kbd_ready,
  output ipod_pkg::flash_req_t          flash_req,
  input  ipod_pkg::flash_rsp_t          flash_rsp,
  output logic [ipod_pkg::sample_w-1:0] audio_data,
  output logic                          sample_valid,
  output ipod_pkg::seg_t [5:0]          hex
);

  ipod_pkg::speed_req_t       speed_req;
  ipod_pkg::player_cmd_e      cmd;
  logic [ipod_pkg::div_w-1:0] div_count;
  logic                       sample_tick;

  // ==========================================================================
  // Input side
  // ==========================================================================
  player_input i_player_input (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .key           (key),
    .kbd_scan_code (kbd_scan_code),
    .kbd_ready     (kbd_ready),
    .speed_req     (speed_req),
    .cmd           (cmd)
  );

  // ==========================================================================
  // Sample pacing and flash playback
  // ==========================================================================
  sample_clock i_sample_clock (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .speed_req   (speed_req),
    .div_count   (div_count),
    .sample_tick (sample_tick)
  );

  flash_reader i_flash_reader (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .cmd          (cmd),
    .sample_tick  (sample_tick),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .audio_data   (audio_data),
    .sample_valid (sample_valid)
  );

  // Divider count on the seven-segment digits
  display_out i_display_out (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .div_count (div_count),
    .hex       (hex)
  );

endmodule

// File: verification/ipod_assert.sv
`timescale 1ns/1ps

module ipod_assert #(
  parameter bit check_flash = 1'b1
) (
  input logic                       CLK_50M,
  input logic                       arst_n,
  input ipod_pkg::flash_req_t       flash_req,
  input ipod_pkg::flash_rsp_t       flash_rsp,
  input logic [ipod_pkg::div_w-1:0] div_count
);

  int fail_cnt = 0;

  generate
    if (check_flash)
    begin : g_flash
      logic read_open;

      // Accepted read still waiting for its data word
      always @(posedge CLK_50M or negedge arst_n)
      begin
        if (!arst_n)
          read_open <= 1'b0;
        else if (flash_rsp.readdatavalid)
          read_open <= 1'b0;
        else if (flash_req.read && !flash_rsp.waitrequest)
          read_open <= 1'b1;
      end

      // ======================================================================
      // Flash handshake
      // ======================================================================
      request_held: assert property (@(posedge CLK_50M) disable iff (!arst_n)
        flash_req.read && flash_rsp.waitrequest |=>
          flash_req.read && $stable(flash_req.address))
      else
      begin
        fail_cnt++;
        $error("read request dropped or address changed under waitrequest");
      end

      single_read: assert property (@(posedge CLK_50M) disable iff (!arst_n)
        flash_req.read |-> !read_open)
      else
      begin
        fail_cnt++;
        $error("second read issued while one is outstanding");
      end

      data_expected: assert property (@(posedge CLK_50M) disable iff (!arst_n)
        flash_rsp.readdatavalid |-> read_open)
      else
      begin
        fail_cnt++;
        $error("readdatavalid without an outstanding read");
      end
    end
    else
    begin : g_div
      // Divider range
      div_in_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
        div_count >= ipod_pkg::min_div && div_count <= ipod_pkg::max_div)
      else
      begin
        fail_cnt++;
        $error("divider count outside its limits");
      end
    end
  endgenerate

endmodule

bind flash_reader ipod_assert #(.check_flash(1'b1)) i_ipod_assert (
  .CLK_50M   (CLK_50M),
  .arst_n    (arst_n),
  .flash_req (flash_req),
  .flash_rsp (flash_rsp),
  .div_count (ipod_pkg::default_div)
);

bind sample_clock ipod_assert #(.check_flash(1'b0)) i_ipod_assert (
  .CLK_50M   (CLK_50M),
  .arst_n    (arst_n),
  .flash_req ('0),
  .flash_rsp ('0),
  .div_count (div_count)
);

// File: verification/tb_simple_ipod.sv
`timescale 1ns/1ps

module tb_simple_ipod;

  // Phases add up to roughly 10k cycles
  localparam int max_cycles    = 40000;
  localparam int min_count     = int'(ipod_pkg::min_div);
  localparam int max_count     = int'(ipod_pkg::max_div);
  localparam int default_count = int'(ipod_pkg::default_div);
  localparam int step_count    = int'(ipod_pkg::speed_step);
  localparam int mode_none     = 0;
  localparam int mode_up       = 1;
  localparam int mode_down     = 2;
  localparam int mode_restore  = 3;

  // Active-low gfedcba patterns of the digits 0 to F
  localparam logic [6:0] seg_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic                          CLK_50M;
  logic                          arst_n;
  logic [2:0]                    key;
  logic [7:0]                    kbd_scan_code;
  logic                          kbd_ready;
  ipod_pkg::flash_req_t          flash_req;
  ipod_pkg::flash_rsp_t          flash_rsp;
  logic [ipod_pkg::sample_w-1:0] audio_data;
  logic                          sample_valid;
  ipod_pkg::seg_t [5:0]          hex;

  integer seed = 60712;
  int     cycle = 0;

  // Reference model of the player
  logic [ipod_pkg::addr_w-1:0] exp_addr = '0;
  logic exp_second = 1'b0;
  logic exp_fwd = 1'b1;
  logic quiet = 1'b1;
  int   sample_cnt = 0;
  int   key_mode = mode_none;
  int   model_div = default_count;
  logic show_check = 1'b0;
  logic gap_check = 1'b0;
  int   gap_cnt = 0;
  int   last_req = -1;
  logic read_prev = 1'b0;

  // Flash model state
  logic in_req = 1'b0;
  int   wait_left = 0;
  int   vld_left = 0;
  logic [ipod_pkg::addr_w-1:0] rsp_addr = '0;

  simple_ipod_top i_dut (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .key           (key),
    .kbd_scan_code (kbd_scan_code),
    .kbd_ready     (kbd_ready),
    .flash_req     (flash_req),
    .flash_rsp     (flash_rsp),
    .audio_data    (audio_data),
    .sample_valid  (sample_valid),
    .hex           (hex)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
  begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles)
      stop_with_failure("Timeout, the run did not finish within the cycle limit");
  end

  task automatic stop_with_failure(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    stop_with_failure($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [31:0] flash_word(logic [ipod_pkg::addr_w-1:0] a);
    return {a[15:0] ^ 16'hA5A5, a[15:0]};
  endfunction

  function automatic logic [ipod_pkg::addr_w-1:0] step_addr(
    logic [ipod_pkg::addr_w-1:0] a, logic fwd);
    if (fwd)
      return (a == ipod_pkg::last_addr) ? '0 : a + 1'b1;
    return (a == '0) ? ipod_pkg::last_addr : a - 1'b1;
  endfunction

  function automatic int next_div(int cur, int mode);
    case (mode)
      mode_up:      return (cur - step_count < min_count) ? min_count : cur - step_count;
      mode_down:    return (cur + step_count > max_count) ? max_count : cur + step_count;
      mode_restore: return default_count;
      default:      return cur;
    endcase
  endfunction

  // Number on the six digits, -1 for an unknown pattern
  function automatic int shown_count(ipod_pkg::seg_t [5:0] digits);
    int value;
    int nib;
    value = 0;
    for (int i = 5; i >= 0; i--)
    begin
      nib = -1;
      for (int n = 0; n < 16; n++)
        if (digits[i] == seg_table[n])
          nib = n;
      if (nib < 0)
        return -1;
      value = value * 16 + nib;
    end
    return value;
  endfunction

  function automatic logic is_player_key(logic [7:0] code);
    return code == ipod_pkg::scan_play || code == ipod_pkg::scan_pause ||
           code == ipod_pkg::scan_forward || code == ipod_pkg::scan_backward ||
           code == ipod_pkg::scan_restart;
  endfunction

  function automatic int bound_fail_count();
    return i_dut.i_flash_reader.i_ipod_assert.fail_cnt +
           i_dut.i_sample_clock.i_ipod_assert.fail_cnt;
  endfunction

  // ==========================================================================
  // Per-cycle checks and flash model, run at each falling edge
  // ==========================================================================
  task automatic check_outputs();
    logic [15:0] exp_data;
    int          shown;
    int          exp_div;
    assert (bound_fail_count() == 0)
      else stop_with_failure("A bound protocol or range assertion failed");
    if (sample_valid)
    begin
      assert (!quiet) else stop_with_failure("sample_valid pulse while the player is paused");
      // Low half first going forward
      exp_data = flash_word(exp_addr) >> ((exp_fwd ^ exp_second) ? 0 : 16);
      assert (audio_data == exp_data)
        else report_mismatch("audio_data", {16'h0, audio_data}, {16'h0, exp_data});
      sample_cnt++;
      if (exp_second)
        exp_addr = step_addr(exp_addr, exp_fwd);
      exp_second = !exp_second;
    end
    if (show_check)
    begin
      shown = shown_count(hex);
      if (shown != model_div)
      begin
        exp_div = next_div(model_div, key_mode);
        assert (shown == exp_div) else report_mismatch("hex count", shown, exp_div);
        model_div = shown;
      end
    end
    if (flash_req.read && !read_prev && gap_check)
    begin
      if (last_req >= 0)
      begin
        assert ((cycle - last_req) % model_div == 0)
          else stop_with_failure($sformatf("Read gap of %0d cycles is not a multiple of %0d",
                                           cycle - last_req, model_div));
        gap_cnt++;
      end
      last_req = cycle;
    end
    read_prev = flash_req.read;
  endtask

  task automatic drive_flash();
    flash_rsp.readdatavalid = 1'b0;
    flash_rsp.readdata      = $random(seed);
    if (vld_left > 0)
    begin
      vld_left--;
      if (vld_left == 0)
      begin
        flash_rsp.readdatavalid = 1'b1;
        flash_rsp.readdata      = flash_word(rsp_addr);
      end
    end
    flash_rsp.waitrequest = 1'b0;
    if (flash_req.read)
    begin
      if (!in_req)
      begin
        in_req    = 1'b1;
        wait_left = rand_below(4);
      end
      if (wait_left > 0)
      begin
        flash_rsp.waitrequest = 1'b1;
        wait_left--;
      end
      else
      begin
        // Accepted at the coming rising edge
        in_req   = 1'b0;
        rsp_addr = flash_req.address;
        vld_left = 1 + rand_below(3);
      end
    end
  endtask

  task automatic wait_cycles(int n);
    repeat (n)
    begin
      @(negedge CLK_50M);
      check_outputs();
      drive_flash();
    end
  endtask

  task automatic send_scan(logic [7:0] code);
    kbd_scan_code = code;
    kbd_ready     = 1'b1;
    wait_cycles(1);
    kbd_ready     = 1'b0;
    wait_cycles(2);
  endtask

  task automatic pause_player();
    send_scan(ipod_pkg::scan_pause);
    wait_cycles(1);
    quiet = 1'b1;
    // Let an outstanding read land and be dropped
    wait_cycles(20);
  endtask

  task automatic hold_key(int mode, int n);
    case (mode)
      mode_up:   key = 3'b110;
      mode_down: key = 3'b101;
      default:   key = 3'b011;
    endcase
    key_mode = mode;
    wait_cycles(n);
    key = 3'b111;
    // Synchronizer and display still carry the last step
    wait_cycles(8);
    key_mode = mode_none;
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial
  begin
    int         start_cnt;
    logic [7:0] code;
    key           = 3'b111;
    kbd_scan_code = '0;
    kbd_ready     = 1'b0;
    flash_rsp     = '0;
    arst_n        = 1'b0;
    repeat (10) @(negedge CLK_50M);
    arst_n = 1'b1;
    wait_cycles(1);
    assert (!flash_req.read && !sample_valid && audio_data == '0 && flash_req.address == '0)
      else stop_with_failure("Outputs are not in their reset state after reset");
    show_check = 1'b1;
    wait_cycles(200);

    // Forward playback from address 0
    quiet = 1'b0;
    send_scan(ipod_pkg::scan_play);
    start_cnt = sample_cnt;
    wait_cycles(3000);
    assert (sample_cnt - start_cnt >= 40)
      else stop_with_failure("Forward playback produced too few samples");

    // Restart, backward, and a long pause
    pause_player();
    send_scan(ipod_pkg::scan_restart);
    exp_addr   = '0;
    exp_second = 1'b0;
    send_scan(ipod_pkg::scan_backward);
    exp_fwd = 1'b0;
    wait_cycles(300);
    quiet = 1'b0;
    send_scan(ipod_pkg::scan_play);
    start_cnt = sample_cnt;
    wait_cycles(2000);
    assert (sample_cnt - start_cnt >= 20)
      else stop_with_failure("Backward playback produced too few samples");
    pause_player();

    // Speed buttons up to both limits, then restore
    hold_key(mode_up, 400);
    assert (model_div == min_count) else report_mismatch("hex count", model_div, min_count);
    hold_key(mode_down, 900);
    assert (model_div == max_count) else report_mismatch("hex count", model_div, max_count);
    hold_key(mode_restore, 20);
    assert (model_div == default_count)
      else report_mismatch("hex count", model_div, default_count);

    // Read spacing after a speed change, with unknown scan codes
    quiet = 1'b0;
    send_scan(ipod_pkg::scan_play);
    hold_key(mode_up, 40);
    wait_cycles(20);
    last_req  = -1;
    gap_check = 1'b1;
    start_cnt = sample_cnt;
    repeat (20)
    begin
      code = 8'($random(seed));
      while (is_player_key(code))
        code = 8'($random(seed));
      send_scan(code);
      wait_cycles(80);
    end
    gap_check = 1'b0;
    assert (sample_cnt - start_cnt >= 20 && gap_cnt >= 10)
      else stop_with_failure("Playback stalled after the speed change");

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: tb.f
src/ipod_pkg.sv
src/player_input.sv
src/sample_clock.sv
src/flash_reader.sv
src/display_out.sv
src/simple_ipod_top.sv
verification/ipod_assert.sv
verification/tb_simple_ipod.sv
